// File: compile.f
hw/gmii_pkg.sv
hw/enc_8b10b.sv
hw/dec_8b10b.sv
hw/tx_pcs.sv
hw/rx_pcs.sv
hw/link_timer.sv
hw/an_fsm.sv
hw/gmii_link.sv
tb/gmii_link_properties.sv
tb/gmii_link_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the loopback testbench with Verilator, status follows the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module gmii_link_tb \
	-f compile.f -o sim_gmii_link
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi
./obj_dir/sim_gmii_link > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if grep -qx "TEST OK" sim.log; then
	exit 0
fi
exit 1

// File: tb/gmii_link_tb.sv
// loopback testbench for gmii_link, txdata feeds rxdata through a los switch
// relies on the fixed 4-cycle txd to rxd latency, timer_ticks kept short at 16
`timescale 1ns/10ps
module gmii_link_tb;

	localparam int ticks  = 16;
	localparam int gap    = 8; // idle after a frame, covers end and extends
	localparam int n_rows = 9;
	localparam logic [15:0] ability_word = 16'h01a0; // full duplex + pause

	typedef struct packed {
		logic [7:0]          len;    // frame bytes, 0 for none
		logic [7:0]          er_idx; // byte with tx_er, ff for none
		logic                los;
		logic                byp;
		logic                exp_op;
		gmii_pkg::an_state_t exp_state;
	} row_t;

	typedef struct packed {
		logic       dv;
		logic       er;
		logic [7:0] d;
	} exp_t;

	// len, er_idx, los, bypass, expected operate, expected state
	localparam row_t rows [n_rows] = '{
		'{8'd0,  8'hff, 1'b0, 1'b0, 1'b0, gmii_pkg::an_restart},
		'{8'd0,  8'hff, 1'b0, 1'b0, 1'b1, gmii_pkg::link_ok},
		'{8'd8,  8'hff, 1'b0, 1'b0, 1'b1, gmii_pkg::link_ok},
		'{8'd17, 8'hff, 1'b0, 1'b0, 1'b1, gmii_pkg::link_ok},
		'{8'd64, 8'hff, 1'b0, 1'b0, 1'b1, gmii_pkg::link_ok},
		'{8'd20, 8'd9,  1'b0, 1'b0, 1'b1, gmii_pkg::link_ok},
		'{8'd12, 8'hff, 1'b1, 1'b0, 1'b1, gmii_pkg::link_ok},
		'{8'd10, 8'hff, 1'b0, 1'b0, 1'b1, gmii_pkg::link_ok},
		'{8'd16, 8'hff, 1'b0, 1'b1, 1'b1, gmii_pkg::link_ok}
	};
	string row_name [n_rows] = '{"reset", "negotiate", "frame_short", "frame_mid",
		"frame_long", "tx_error", "loss_of_signal", "frame_relink", "bypass"};

	logic                 GTX_CLK, rst, tx_en, tx_er, rx_dv, rx_er, los, an_bypass, operate;
	logic [7:0]           txd, rxd;
	logic [9:0]           txdata, rxdata;
	logic [15:0]          ability, lacr_rx;
	gmii_pkg::an_status_t an_status;
	logic [31:0]          lfsr = 32'h0e7e0849;
	logic                 accept; // offered frame should come out
	exp_t                 pipe [$]; // byte side, 4 cycles deep
	string                cur_name;
	int                   n_checks, n_errors, n_failed;

	always #50 GTX_CLK = ~GTX_CLK;

	always_comb rxdata = los ? 10'b0000000000 : txdata; // all zeros is no code group

	gmii_link #(.timer_ticks(ticks)) u_gmii_link (.GTX_CLK, .rst, .txd, .tx_en, .tx_er, .rxd,
		.rx_dv, .rx_er, .txdata, .rxdata, .rx_los(los), .an_bypass, .ability, .operate,
		.an_status, .lacr_rx);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
	endfunction

	task automatic take_byte(output logic [7:0] b);
		b = 8'h00;
		for (int k = 0; k < 8; k++) begin
			lfsr = lfsr_next(lfsr); // one step per bit
			b = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("mismatch %s %s: expected %b actual %b", cur_name, what, exp, act);
		end
	endtask

	task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("mismatch %s %s: expected %h actual %h", cur_name, what, exp, act);
		end
	endtask

	task automatic check_word(input string what, input logic [15:0] exp,
			input logic [15:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("mismatch %s %s: expected %h actual %h", cur_name, what, exp, act);
		end
	endtask

	task automatic check_status(input gmii_pkg::an_status_t exp,
			input gmii_pkg::an_status_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("mismatch %s an_status: expected %s sync/ack/seen %b%b%b actual %s %b%b%b",
				cur_name, exp.state.name(), exp.sync_ok, exp.rx_ack, exp.rx_ability_seen,
				act.state.name(), act.sync_ok, act.rx_ack, act.rx_ability_seen);
		end
	endtask

	task automatic apply_reset(input logic byp);
		@(posedge GTX_CLK);
		rst <= 1'b1;
		an_bypass <= byp;
		los <= 1'b0;
		repeat (4) @(posedge GTX_CLK);
		rst <= 1'b0;
	endtask

	task automatic wait_operate();
		int n;
		n = 0;
		@(negedge GTX_CLK);
		while (!operate && n < 16 * ticks) begin
			@(negedge GTX_CLK);
			n++;
		end
		if (!operate) begin
			n_errors++;
			$display("%s: operate did not rise within %0d cycles", cur_name, 16 * ticks);
		end
	endtask

	// preamble 55 55 d5, rest from the lfsr
	task automatic send_frame(input int len, input int er_idx);
		logic [7:0] b;
		for (int i = 0; i < len; i++) begin
			if (i < 2)
				b = 8'h55;
			else if (i == 2)
				b = 8'hd5;
			else
				take_byte(b);
			@(posedge GTX_CLK);
			txd <= b;
			tx_en <= 1'b1;
			tx_er <= (i == er_idx);
		end
		@(posedge GTX_CLK);
		txd <= 8'h00;
		tx_en <= 1'b0;
		tx_er <= 1'b0;
		repeat (gap) @(posedge GTX_CLK);
	endtask

	task automatic run_row(input int i);
		row_t                 r;
		int                   errs0;
		logic                 neg;
		gmii_pkg::an_status_t exp_st;
		r = rows[i];
		cur_name = row_name[i];
		errs0 = n_errors;
		neg = r.exp_op && !r.byp; // negotiated link holds the acked ability
		if (i == 0 || r.byp !== an_bypass)
			apply_reset(r.byp);
		if (r.exp_op && !r.los)
			wait_operate();
		accept = !r.los;
		if (r.los) begin
			@(posedge GTX_CLK);
			los <= 1'b1;
			@(negedge GTX_CLK);
			@(negedge GTX_CLK); // one cycle later
			check_flag("operate after los", 1'b0, operate);
			check_status('{state: gmii_pkg::an_restart, sync_ok: 1'b0, rx_ack: 1'b1,
				rx_ability_seen: 1'b1}, an_status); // last word still held
		end
		if (r.len != 0)
			send_frame(r.len, r.er_idx); // dropped whole during an outage
		if (r.los) begin
			@(posedge GTX_CLK);
			los <= 1'b0;
			wait_operate(); // renegotiates
		end
		@(negedge GTX_CLK);
		check_flag("operate", r.exp_op, operate);
		check_flag("rx_dv idle", 1'b0, rx_dv);
		exp_st = '{state: r.exp_state, sync_ok: 1'b1, rx_ack: neg, rx_ability_seen: neg};
		check_status(exp_st, an_status);
		check_word("lacr_rx", neg ? (ability_word | (16'd1 << gmii_pkg::ack_bit)) : 16'd0,
			lacr_rx);
		if (n_errors != errs0)
			n_failed++;
		$display("%-16s %s, %0d errors", cur_name, (n_errors == errs0) ? "passed" : "failed",
			n_errors - errs0);
	endtask

	// byte side compare, outputs read at the falling edge
	always @(negedge GTX_CLK) begin
		exp_t e;
		pipe.push_back('{dv: tx_en && accept, er: tx_er, d: txd});
		if (pipe.size() > 4) begin
			e = pipe.pop_front();
			check_flag("rx_dv", e.dv, rx_dv);
			check_flag("rx_er", e.dv && e.er, rx_er);
			if (e.dv && !e.er)
				check_byte("rxd", e.d, rxd); // error byte carries K30.7 data
		end
	end

	initial begin
		GTX_CLK = 1'b0;
		rst = 1'b1;
		txd = 8'h00;
		tx_en = 1'b0;
		tx_er = 1'b0;
		los = 1'b0;
		an_bypass = 1'b0;
		ability = ability_word;
		accept = 1'b1;
		for (int i = 0; i < n_rows; i++)
			run_row(i);
		$display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
			n_rows, n_failed, n_checks, n_errors, u_gmii_link.u_props.n_fail);
		if (n_errors == 0 && u_gmii_link.u_props.n_fail == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// frames + gaps + resets, 8 timer periods per negotiation, doubled
	initial begin
		int limit;
		limit = 8 * ticks; // first negotiation
		for (int i = 0; i < n_rows; i++) begin
			limit += rows[i].len + gap + 8;
			if (rows[i].los)
				limit += 8 * ticks;
		end
		limit = 2 * limit;
		repeat (limit) @(posedge GTX_CLK);
		$display("timeout: run did not finish within %0d cycles", limit);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: tb/gmii_link_properties.sv
// bound into gmii_link, watches line coding, reset release and frame gating
// start check uses the cycle before since tx_pcs registers its symbol
`timescale 1ns/10ps
module gmii_link_properties (
	input logic           GTX_CLK,
	input logic           rst,
	input logic [9:0]     txdata,
	input logic           operate,
	input logic           link_up,
	input gmii_pkg::sym_t tx_sym
);

	int n_fail = 0; // failed properties so far

	// every valid code group is 4, 5 or 6 ones
	a_ones: assert property (@(posedge GTX_CLK) disable iff (rst)
		$countones(txdata) inside {[4:6]})
		else begin
			$error("txdata word %b has %0d ones", txdata, $countones(txdata));
			n_fail++;
		end

	a_reset_op: assert property (@(posedge GTX_CLK) $fell(rst) |-> !operate)
		else begin
			$error("operate high in the first cycle after reset");
			n_fail++;
		end

	a_start_gate: assert property (@(posedge GTX_CLK) disable iff (rst)
		tx_sym == gmii_pkg::k27_7 |-> $past(link_up))
		else begin
			$error("start symbol sent while link_up low");
			n_fail++;
		end

endmodule

bind gmii_link gmii_link_properties u_props (.GTX_CLK, .rst, .txdata, .operate, .link_up,
	.tx_sym);

// File: hw/gmii_link.sv
// 1000BASE-X link top, both paths on GTX_CLK, serdes words must arrive aligned
// loopback latency txd to rxd is 4 cycles
`timescale 1ns/10ps
module gmii_link #(
	parameter int timer_ticks = 1250000 // cycles per timed negotiation phase
) (
	input  logic                 GTX_CLK,
	input  logic                 rst,
	input  logic [7:0]           txd,
	input  logic                 tx_en,
	input  logic                 tx_er,
	output logic [7:0]           rxd,
	output logic                 rx_dv,
	output logic                 rx_er,
	output logic [9:0]           txdata,
	input  logic [9:0]           rxdata,
	input  logic                 rx_los,
	input  logic                 an_bypass,
	input  logic [15:0]          ability,
	output logic                 operate,
	output gmii_pkg::an_status_t an_status,
	output logic [15:0]          lacr_rx
);

	gmii_pkg::sym_t    tx_sym, rx_sym;
	gmii_pkg::tx_sel_t tx_sel;
	logic [15:0]       cfg_word, cfg_rx;
	logic              link_up, code_err, disp_err;
	logic              cfg_stb, idle_rx, sync_ok, timer_start, timer_done;

	tx_pcs u_tx_pcs (.GTX_CLK, .rst, .txd, .tx_en, .tx_er, .link_up, .tx_sel, .cfg_word,
		.sym_out(tx_sym));

	enc_8b10b u_enc (.GTX_CLK, .rst, .sym_in(tx_sym), .code_out(txdata));

	dec_8b10b u_dec (.GTX_CLK, .rst, .code_in(rxdata), .sym_out(rx_sym), .code_err,
		.disp_err);

	rx_pcs u_rx_pcs (.GTX_CLK, .rst, .sym_in(rx_sym), .code_err, .disp_err, .rx_los, .rxd,
		.rx_dv, .rx_er, .cfg_rx, .cfg_stb, .idle_rx, .sync_ok);

	an_fsm u_an_fsm (.GTX_CLK, .rst, .an_bypass, .ability, .cfg_rx, .cfg_stb, .idle_rx,
		.sync_ok, .timer_done, .timer_start, .tx_sel, .cfg_word, .link_up, .operate,
		.an_status, .lacr_rx);

	link_timer #(.timer_ticks(timer_ticks)) u_timer (.GTX_CLK, .rst, .timer_start,
		.timer_done);

endmodule

// File: hw/an_fsm.sv
// clause-37-style auto-negotiation, base page only
// timer_done is ignored in the cycle that timer_start is high, the timer loads one cycle late
`timescale 1ns/10ps
module an_fsm (
	input  logic                 GTX_CLK,
	input  logic                 rst,
	input  logic                 an_bypass,
	input  logic [15:0]          ability,
	input  logic [15:0]          cfg_rx,
	input  logic                 cfg_stb,
	input  logic                 idle_rx,
	input  logic                 sync_ok,
	input  logic                 timer_done,
	output logic                 timer_start,
	output gmii_pkg::tx_sel_t    tx_sel,
	output logic [15:0]          cfg_word,
	output logic                 link_up,
	output logic                 operate,
	output gmii_pkg::an_status_t an_status,
	output logic [15:0]          lacr_rx
);

	gmii_pkg::an_state_t state, nxt;
	logic t_ok, restart_t, seen;

	assign t_ok = timer_done && !timer_start;

	always_comb begin
		nxt = state;
		restart_t = 1'b0;
		if (!sync_ok) begin
			nxt = gmii_pkg::an_restart; // hold restart while out of sync
			restart_t = 1'b1;
		end else if (an_bypass) begin
			nxt = gmii_pkg::link_ok;
		end else begin
			case (state)
				gmii_pkg::an_restart: if (t_ok) nxt = gmii_pkg::ability_detect;
				gmii_pkg::ability_detect: if (cfg_stb && cfg_rx != 16'd0) nxt = gmii_pkg::ack_detect;
				gmii_pkg::ack_detect: begin
					if (cfg_stb && cfg_rx[gmii_pkg::ack_bit]) begin
						nxt = gmii_pkg::complete_ack;
						restart_t = 1'b1;
					end
				end
				gmii_pkg::complete_ack: begin
					if (t_ok) begin
						nxt = gmii_pkg::idle_detect;
						restart_t = 1'b1;
					end
				end
				gmii_pkg::idle_detect: begin
					if (!idle_rx)
						restart_t = 1'b1; // period counts from idle seen
					else if (t_ok)
						nxt = gmii_pkg::link_ok;
				end
				default: begin
					if (cfg_stb && cfg_rx == 16'd0) begin
						nxt = gmii_pkg::an_restart; // partner restarted
						restart_t = 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge GTX_CLK) begin
		if (rst) begin
			state <= gmii_pkg::an_restart;
			timer_start <= 1'b1; // times the first restart
			seen <= 1'b0;
			lacr_rx <= 16'd0;
		end else begin
			state <= nxt;
			timer_start <= restart_t;
			if (cfg_stb) begin
				lacr_rx <= cfg_rx;
				seen <= seen | (cfg_rx != 16'd0);
			end
		end
	end

	always_comb begin
		operate = state == gmii_pkg::link_ok;
		link_up = operate;
		tx_sel = (state == gmii_pkg::link_ok) ? gmii_pkg::send_data :
			(state == gmii_pkg::idle_detect) ? gmii_pkg::send_idle : gmii_pkg::send_config;
		cfg_word = (state == gmii_pkg::an_restart) ? 16'd0 :
			(state == gmii_pkg::ability_detect) ? ability : ability | (16'd1 << gmii_pkg::ack_bit);
		an_status = '{state: state, sync_ok: sync_ok, rx_ack: lacr_rx[gmii_pkg::ack_bit],
			rx_ability_seen: seen};
	end

endmodule

// File: hw/link_timer.sv
// restartable down-counter, timer_done stays high at zero until the next start
`timescale 1ns/10ps
module link_timer #(
	parameter int timer_ticks = 1250000
) (
	input  logic GTX_CLK,
	input  logic rst,
	input  logic timer_start,
	output logic timer_done
);

	localparam int cw = (timer_ticks < 1) ? 1 : $clog2(timer_ticks + 1);

	logic [cw-1:0] count;

	always_ff @(posedge GTX_CLK) begin
		if (rst)
			count <= '0;
		else if (timer_start)
			count <= cw'(timer_ticks); // reload
		else if (count != '0)
			count <= count - 1'b1;
	end

	assign timer_done = count == '0;

endmodule

// File: hw/rx_pcs.sv
// receive ordered-set parser, outputs registered one cycle after the decoder
// sync_ok is combinational; cfg_stb needs two equal config words in a row
`timescale 1ns/10ps
module rx_pcs (
	input  logic           GTX_CLK,
	input  logic           rst,
	input  gmii_pkg::sym_t sym_in,
	input  logic           code_err,
	input  logic           disp_err,
	input  logic           rx_los,
	output logic [7:0]     rxd,
	output logic           rx_dv,
	output logic           rx_er,
	output logic [15:0]    cfg_rx,
	output logic           cfg_stb,
	output logic           idle_rx,
	output logic           sync_ok
);

	logic        err;
	logic        in_frame;
	logic        prev_ok; // cfg_prev holds a good word
	logic [1:0]  cnt;     // symbols since comma
	logic [7:0]  cfg_lo;
	logic [15:0] cfg_prev;

	assign err = code_err | disp_err;
	assign sync_ok = !(err || rx_los);

	always_ff @(posedge GTX_CLK) begin
		if (rst) begin
			cnt <= 2'd0;
			prev_ok <= 1'b0;
			cfg_stb <= 1'b0;
			idle_rx <= 1'b0;
		end else begin
			cfg_stb <= 1'b0;
			if (!sync_ok) begin
				cnt <= 2'd0;
				prev_ok <= 1'b0;
			end else if (sym_in == gmii_pkg::k28_5) begin
				cnt <= 2'd1;
			end else begin
				case (cnt)
					2'd1: begin
						if (sym_in == gmii_pkg::d21_5 || sym_in == gmii_pkg::d2_2) begin
							cnt <= 2'd2;
							idle_rx <= 1'b0;
						end else begin
							cnt <= 2'd0;
							if (sym_in == gmii_pkg::d16_2) begin
								idle_rx <= 1'b1;
								prev_ok <= 1'b0;
							end
						end
					end
					2'd2: begin
						cfg_lo <= sym_in.data; // low byte first
						cnt <= sym_in.is_k ? 2'd0 : 2'd3;
					end
					2'd3: begin
						cnt <= 2'd0;
						if (!sym_in.is_k) begin
							cfg_prev <= {sym_in.data, cfg_lo};
							prev_ok <= 1'b1;
							if (prev_ok && cfg_prev == {sym_in.data, cfg_lo}) begin
								cfg_stb <= 1'b1;
								cfg_rx <= cfg_prev;
							end
						end
					end
					default: cnt <= 2'd0;
				endcase
			end
		end
	end

	// frame side
	always_ff @(posedge GTX_CLK) begin
		rxd <= in_frame ? sym_in.data : gmii_pkg::preamble.data;
		if (rst || rx_los) begin
			in_frame <= 1'b0;
			rx_dv <= 1'b0;
			rx_er <= 1'b0;
		end else if (!in_frame) begin
			rx_er <= 1'b0;
			in_frame <= sym_in == gmii_pkg::k27_7 && !err;
			rx_dv <= sym_in == gmii_pkg::k27_7 && !err; // start shows as preamble
		end else if (err || sym_in == gmii_pkg::k30_7) begin
			rx_dv <= 1'b1;
			rx_er <= 1'b1;
		end else begin
			in_frame <= !sym_in.is_k; // end or any other K closes
			rx_dv <= !sym_in.is_k;
			rx_er <= 1'b0;
		end
	end

endmodule

// File: hw/tx_pcs.sv
// transmit ordered-set generator, one symbol per GTX_CLK, sym_out registered
// frames start only on a tx_en rising edge with link_up high, otherwise dropped whole
`timescale 1ns/10ps
module tx_pcs (
	input  logic              GTX_CLK,
	input  logic              rst,
	input  logic [7:0]        txd,
	input  logic              tx_en,
	input  logic              tx_er,
	input  logic              link_up,
	input  gmii_pkg::tx_sel_t tx_sel,
	input  logic [15:0]       cfg_word,
	output gmii_pkg::sym_t    sym_out
);

	logic       tx_en_d;
	logic       in_frame;
	logic [1:0] ext_left; // carrier extends still to send
	logic [1:0] pos;      // position inside ordered set
	logic       cfg_alt;  // config 1 / config 2 toggle
	logic       start;

	assign start = tx_en && !tx_en_d && link_up;

	always_ff @(posedge GTX_CLK) begin
		if (rst) begin
			tx_en_d <= 1'b0;
			in_frame <= 1'b0;
			ext_left <= 2'd0;
			pos <= 2'd0;
			cfg_alt <= 1'b0;
			sym_out <= gmii_pkg::k28_5;
		end else begin
			tx_en_d <= tx_en;
			pos <= pos + 2'd1;
			if (in_frame && tx_en) begin
				sym_out <= tx_er ? gmii_pkg::k30_7 : '{is_k: 1'b0, data: txd};
			end else if (in_frame) begin
				sym_out <= gmii_pkg::k29_7; // end of packet
				in_frame <= 1'b0;
				ext_left <= pos[0] ? 2'd2 : 2'd1; // odd end needs a 2nd extend
			end else if (ext_left != 2'd0) begin
				sym_out <= gmii_pkg::k23_7;
				ext_left <= ext_left - 2'd1;
				if (ext_left == 2'd1)
					pos <= 2'd0; // next set starts clean
			end else if (start) begin
				sym_out <= gmii_pkg::k27_7; // replaces first byte
				in_frame <= 1'b1;
			end else if (tx_sel == gmii_pkg::send_config) begin
				case (pos)
					2'd0: sym_out <= gmii_pkg::k28_5;
					2'd1: sym_out <= cfg_alt ? gmii_pkg::d2_2 : gmii_pkg::d21_5;
					2'd2: sym_out <= '{is_k: 1'b0, data: cfg_word[7:0]};
					default: begin
						sym_out <= '{is_k: 1'b0, data: cfg_word[15:8]};
						cfg_alt <= ~cfg_alt;
					end
				endcase
			end else begin
				sym_out <= pos[0] ? gmii_pkg::d16_2 : gmii_pkg::k28_5; // idle pair
			end
		end
	end

endmodule

// File: hw/dec_8b10b.sv
// registered 8b/10b decoder, expects aligned words, running disparity starts negative
// a word outside the table sets code_err; sym_out is then don't-care
`timescale 1ns/10ps
module dec_8b10b (
	input  logic           GTX_CLK,
	input  logic           rst,
	input  logic [9:0]     code_in,
	output gmii_pkg::sym_t sym_out,
	output logic           code_err,
	output logic           disp_err
);

	logic       rd;
	logic       rd6, rd4;   // disparity each sub-block was coded against
	logic       rd_mid, rd_next;
	logic       hit6, hit4, k28, alt_dec, derr;
	logic [4:0] x_dec;
	logic [2:0] y_dec;
	logic [5:0] c6;
	logic [3:0] c4;

	always_comb begin
		c6 = code_in[9:4];
		c4 = code_in[3:0];
		// unbalanced code tells its own entry disparity
		rd6 = ($countones(c6) == 3) ? rd : ($countones(c6) < 3);
		rd_mid = ($countones(c6) == 3) ? rd : ($countones(c6) > 3);
		hit6 = 1'b0;
		k28 = 1'b0;
		x_dec = 5'd0;
		for (int i = 0; i < 32; i++) begin
			if (gmii_pkg::enc6(5'(i), 1'b0, rd6) == c6) begin
				hit6 = 1'b1;
				x_dec = 5'(i);
			end
		end
		if (gmii_pkg::enc6(5'd28, 1'b1, rd6) == c6) begin
			hit6 = 1'b1; // K28 form
			k28 = 1'b1;
			x_dec = 5'd28;
		end
		rd4 = ($countones(c4) == 2) ? rd_mid : ($countones(c4) < 2);
		rd_next = ($countones(c4) == 2) ? rd_mid : ($countones(c4) > 2);
		hit4 = 1'b0;
		alt_dec = 1'b0;
		y_dec = 3'd0;
		for (int j = 0; j < 16; j++) begin
			if (gmii_pkg::enc4(3'(j), j[3], k28, rd4) == c4) begin
				hit4 = 1'b1;
				y_dec = 3'(j);
				alt_dec = j[3];
			end
		end
		derr = ($countones(c6) != 3 && rd6 != rd) || ($countones(c4) != 2 && rd4 != rd_mid);
	end

	always_ff @(posedge GTX_CLK) begin
		sym_out.data <= {y_dec, x_dec};
		// A7 with these x is only used for K codes
		sym_out.is_k <= k28 || (alt_dec && (x_dec == 5'd23 || x_dec == 5'd27 ||
			x_dec == 5'd29 || x_dec == 5'd30));
		if (rst) begin
			rd <= 1'b0;
			code_err <= 1'b0;
			disp_err <= 1'b0;
		end else begin
			rd <= rd_next; // follow the word even when in error
			code_err <= !(hit6 && hit4);
			disp_err <= derr;
		end
	end

endmodule

// File: hw/enc_8b10b.sv
// registered 8b/10b encoder, running disparity starts negative after reset
// no check on illegal K codes, only K28.5, K23.7, K27.7, K29.7, K30.7 are meaningful
`timescale 1ns/10ps
module enc_8b10b (
	input  logic          GTX_CLK,
	input  logic          rst,
	input  gmii_pkg::sym_t sym_in,
	output logic [9:0]    code_out
);

	logic       rd;       // running disparity, 1 = positive
	logic       rd_mid;   // after the 6b block
	logic       rd_next;
	logic       k28;
	logic       alt;
	logic [4:0] x;
	logic [2:0] y;
	logic [5:0] c6;
	logic [3:0] c4;

	always_comb begin
		x = sym_in.data[4:0];
		y = sym_in.data[7:5];
		k28 = sym_in.is_k && x == 5'd28;
		c6 = gmii_pkg::enc6(x, k28, rd);
		rd_mid = ($countones(c6) != 3) ? ~rd : rd; // unbalanced flips
		// A7 avoids a run of five
		alt = y == 3'd7 && (sym_in.is_k ||
			(!rd_mid && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
			(rd_mid && (x == 5'd11 || x == 5'd13 || x == 5'd14)));
		c4 = gmii_pkg::enc4(y, alt, k28, rd_mid);
		rd_next = ($countones(c4) != 2) ? ~rd_mid : rd_mid;
	end

	always_ff @(posedge GTX_CLK) begin
		if (rst) begin
			rd <= 1'b0;
			code_out <= 10'b1010101010; // balanced D21.5, keeps rd negative
		end else begin
			rd <= rd_next;
			code_out <= {c6, c4};
		end
	end

endmodule

// File: hw/gmii_pkg.sv
// shared types and 8b/10b tables for the 1000BASE-X link
// code words are {a,b,c,d,e,i,f,g,h,j}, bit 9 first on the wire; rd 1 means positive
package gmii_pkg;

	typedef struct packed {
		logic       is_k; // control code group
		logic [7:0] data;
	} sym_t;

	typedef enum logic [2:0] {
		an_restart, ability_detect, ack_detect, complete_ack, idle_detect, link_ok
	} an_state_t;

	typedef struct packed {
		an_state_t state;
		logic      sync_ok;         // no decode error or los this cycle
		logic      rx_ack;          // ack bit of last strobed config word
		logic      rx_ability_seen; // nonzero config word seen
	} an_status_t;

	typedef enum logic [1:0] {send_idle, send_config, send_data} tx_sel_t;

	parameter sym_t k28_5    = '{is_k: 1'b1, data: 8'hbc}; // comma
	parameter sym_t k27_7    = '{is_k: 1'b1, data: 8'hfb}; // start
	parameter sym_t k29_7    = '{is_k: 1'b1, data: 8'hfd}; // end
	parameter sym_t k23_7    = '{is_k: 1'b1, data: 8'hf7}; // carrier extend
	parameter sym_t k30_7    = '{is_k: 1'b1, data: 8'hfe}; // error propagation
	parameter sym_t d16_2    = '{is_k: 1'b0, data: 8'h50}; // idle 2nd symbol
	parameter sym_t d21_5    = '{is_k: 1'b0, data: 8'hb5}; // config 1
	parameter sym_t d2_2     = '{is_k: 1'b0, data: 8'h42}; // config 2
	parameter sym_t preamble = '{is_k: 1'b0, data: 8'h55};

	parameter int ack_bit = 14; // ack flag in config word

	// 5b/6b, rd- column; rd+ is the complement for unbalanced codes and D.7
	function automatic logic [5:0] enc6(input logic [4:0] x, input logic k28, input logic rd);
		logic [5:0] t;
		case (x)
			5'd0: t = 6'b100111;  5'd1: t = 6'b011101;  5'd2: t = 6'b101101;
			5'd3: t = 6'b110001;  5'd4: t = 6'b110101;  5'd5: t = 6'b101001;
			5'd6: t = 6'b011001;  5'd7: t = 6'b111000;  5'd8: t = 6'b111001;
			5'd9: t = 6'b100101;  5'd10: t = 6'b010101; 5'd11: t = 6'b110100;
			5'd12: t = 6'b001101; 5'd13: t = 6'b101100; 5'd14: t = 6'b011100;
			5'd15: t = 6'b010111; 5'd16: t = 6'b011011; 5'd17: t = 6'b100011;
			5'd18: t = 6'b010011; 5'd19: t = 6'b110010; 5'd20: t = 6'b001011;
			5'd21: t = 6'b101010; 5'd22: t = 6'b011010; 5'd23: t = 6'b111010;
			5'd24: t = 6'b110011; 5'd25: t = 6'b100110; 5'd26: t = 6'b010110;
			5'd27: t = 6'b110110; 5'd28: t = 6'b001110; 5'd29: t = 6'b101110;
			5'd30: t = 6'b011110; default: t = 6'b101011;
		endcase
		if (k28)
			t = 6'b001111;
		if (rd && ($countones(t) != 3 || (x == 5'd7 && !k28)))
			t = ~t;
		return t;
	endfunction

	// 3b/4b, alt selects the A7 form; K28 flips balanced codes under rd-
	function automatic logic [3:0] enc4(input logic [2:0] y, input logic alt, input logic k28,
			input logic rd);
		logic [3:0] t;
		case (y)
			3'd0: t = 4'b1011; 3'd1: t = 4'b1001; 3'd2: t = 4'b0101; 3'd3: t = 4'b1100;
			3'd4: t = 4'b1101; 3'd5: t = 4'b1010; 3'd6: t = 4'b0110; default: t = 4'b1110;
		endcase
		if (alt)
			t = 4'b0111;
		if (rd && ($countones(t) != 2 || y == 3'd3))
			t = ~t;
		else if (k28 && !rd && $countones(t) == 2)
			t = ~t;
		return t;
	endfunction

endpackage
